//--- src/trace_pkg.sv
package trace_pkg;

    typedef logic [7:0]  char_t;
    typedef logic [15:0] time_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] reg_num_t;

    // Bit 3 reg, bit 2 addr, bit 1 pc, bit 0 time
    typedef logic [3:0]  error_code_t;

    typedef enum logic [3:0] {
        CLS_CARET, CLS_DIGIT, CLS_AT, CLS_HEX,
        CLS_SPACE, CLS_STAR, CLS_EQUALS, CLS_LESS,
        CLS_DOLLAR, CLS_HASH, CLS_COLON, CLS_OTHER
    } char_class_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_TIME, ST_AT,
        ST_PC, ST_COLON_SPACE, ST_REG_FIRST, ST_REG,
        ST_ADDR_FIRST, ST_ADDR, ST_PRE_ARROW, ST_ARROW,
        ST_DATA_SPACE, ST_DATA
    } parse_state_e;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_REG  = 2'd1,
        KIND_MEM  = 2'd2
    } record_kind_e;

    typedef struct packed {
        char_t       ch;
        char_class_e cls;
    } char_token_t;

    typedef struct packed {
        record_kind_e kind;
        time_t        time_val;
        word_t        pc;
        word_t        addr;
        reg_num_t     reg_num;
    } trace_record_t;

    typedef struct packed {
        record_kind_e kind;
        error_code_t  error;
    } check_result_t;

endpackage

//--- src/char_classifier.sv
module char_classifier (
    input  logic                   clk,
    input  logic                   reset,
    input  trace_pkg::char_t       char,
    input  logic                   char_valid,
    output trace_pkg::char_token_t token,
    output logic                   token_valid
);
    import trace_pkg::*;

    char_class_e cls;

    // Classes are disjoint, first match wins
    always_comb begin
        case (char) inside
            "^":        cls = CLS_CARET;
            ["0":"9"]:  cls = CLS_DIGIT;
            "@":        cls = CLS_AT;
            ["a":"f"]:  cls = CLS_HEX;
            " ":        cls = CLS_SPACE;
            "*":        cls = CLS_STAR;
            "=":        cls = CLS_EQUALS;
            "<":        cls = CLS_LESS;
            "$":        cls = CLS_DOLLAR;
            "#":        cls = CLS_HASH;
            ":":        cls = CLS_COLON;
            default:    cls = CLS_OTHER;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            token_valid <= 1'b0;
        end else begin
            token_valid <= char_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (char_valid) begin
            token.ch  <= char;
            token.cls <= cls;
        end
    end

endmodule

//--- src/trace_parser.sv
module trace_parser (
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::char_token_t   token,
    input  logic                     token_valid,
    output trace_pkg::trace_record_t record,
    output logic                     record_valid
);
    import trace_pkg::*;

    parse_state_e state;
    logic [3:0]   digit_cnt;
    record_kind_e kind;
    time_t        time_val;
    word_t        pc;
    word_t        addr;
    reg_num_t     reg_num;
    logic         is_dec;
    logic         is_hex;
    logic [3:0]   dec;
    logic [3:0]   nib;

    assign is_dec = (token.cls == CLS_DIGIT);
    assign is_hex = is_dec || (token.cls == CLS_HEX);

    // ASCII low nibble gives the digit, letters a-f need 9 more
    assign dec = token.ch[3:0];
    assign nib = (token.cls == CLS_HEX) ? token.ch[3:0] + 4'd9 : token.ch[3:0];

    assign record = '{kind: kind, time_val: time_val, pc: pc, addr: addr, reg_num: reg_num};

    ////////////////////////////////////////
    // Line syntax FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            digit_cnt    <= '0;
            record_valid <= 1'b0;
        end else begin
            record_valid <= 1'b0;
            if (token_valid) begin
                // Anything not matched below drops the line
                state     <= ST_IDLE;
                digit_cnt <= '0;
                if (token.cls == CLS_CARET) begin
                    state <= ST_START;
                end else begin
                    case (state)
                        ST_START: begin
                            if (is_dec) begin
                                state     <= ST_TIME;
                                digit_cnt <= 4'd1;
                            end
                        end
                        ST_TIME: begin
                            if (is_dec && digit_cnt < 4'd4) begin
                                state     <= ST_TIME;
                                digit_cnt <= digit_cnt + 4'd1;
                            end else if (token.cls == CLS_AT) begin
                                state <= ST_AT;
                            end
                        end
                        ST_AT: begin
                            if (is_hex) begin
                                state     <= ST_PC;
                                digit_cnt <= 4'd1;
                            end
                        end
                        ST_PC: begin
                            if (is_hex && digit_cnt < 4'd8) begin
                                state     <= ST_PC;
                                digit_cnt <= digit_cnt + 4'd1;
                            end else if (token.cls == CLS_COLON && digit_cnt == 4'd8) begin
                                state <= ST_COLON_SPACE;
                            end
                        end
                        ST_COLON_SPACE: begin
                            if (token.cls == CLS_SPACE)
                                state <= ST_COLON_SPACE;
                            else if (token.cls == CLS_DOLLAR)
                                state <= ST_REG_FIRST;
                            else if (token.cls == CLS_STAR)
                                state <= ST_ADDR_FIRST;
                        end
                        ST_REG_FIRST: begin
                            if (is_dec) begin
                                state     <= ST_REG;
                                digit_cnt <= 4'd1;
                            end
                        end
                        ST_REG: begin
                            if (is_dec && digit_cnt < 4'd4) begin
                                state     <= ST_REG;
                                digit_cnt <= digit_cnt + 4'd1;
                            end else if (token.cls == CLS_SPACE) begin
                                state <= ST_PRE_ARROW;
                            end else if (token.cls == CLS_LESS) begin
                                state <= ST_ARROW;
                            end
                        end
                        ST_ADDR_FIRST: begin
                            if (is_hex) begin
                                state     <= ST_ADDR;
                                digit_cnt <= 4'd1;
                            end
                        end
                        ST_ADDR: begin
                            if (is_hex && digit_cnt < 4'd8) begin
                                state     <= ST_ADDR;
                                digit_cnt <= digit_cnt + 4'd1;
                            end else if (digit_cnt == 4'd8 && token.cls == CLS_SPACE) begin
                                state <= ST_PRE_ARROW;
                            end else if (digit_cnt == 4'd8 && token.cls == CLS_LESS) begin
                                state <= ST_ARROW;
                            end
                        end
                        ST_PRE_ARROW: begin
                            if (token.cls == CLS_SPACE)
                                state <= ST_PRE_ARROW;
                            else if (token.cls == CLS_LESS)
                                state <= ST_ARROW;
                        end
                        ST_ARROW: begin
                            if (token.cls == CLS_EQUALS)
                                state <= ST_DATA_SPACE;
                        end
                        ST_DATA_SPACE: begin
                            if (token.cls == CLS_SPACE) begin
                                state <= ST_DATA_SPACE;
                            end else if (is_hex) begin
                                state     <= ST_DATA;
                                digit_cnt <= 4'd1;
                            end
                        end
                        ST_DATA: begin
                            if (is_hex && digit_cnt < 4'd8) begin
                                state     <= ST_DATA;
                                digit_cnt <= digit_cnt + 4'd1;
                            end else if (token.cls == CLS_HASH && digit_cnt == 4'd8) begin
                                record_valid <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // First digit of a field reloads it
    always_ff @(posedge clk) begin
        if (token_valid) begin
            case (state)
                ST_START:      time_val <= time_t'(dec);
                ST_TIME:       if (is_dec) time_val <= time_val * 16'd10 + time_t'(dec);
                ST_AT:         pc <= word_t'(nib);
                ST_PC:         if (is_hex) pc <= {pc[27:0], nib};
                ST_COLON_SPACE: begin
                    if (token.cls == CLS_DOLLAR)
                        kind <= KIND_REG;
                    else if (token.cls == CLS_STAR)
                        kind <= KIND_MEM;
                end
                ST_REG_FIRST:  reg_num <= reg_num_t'(dec);
                ST_REG:        if (is_dec) reg_num <= reg_num * 16'd10 + reg_num_t'(dec);
                ST_ADDR_FIRST: addr <= word_t'(nib);
                ST_ADDR:       if (is_hex) addr <= {addr[27:0], nib};
                default: ;
            endcase
        end
    end

    a_digit_cnt_max: assert property (@(posedge clk) disable iff (reset)
        digit_cnt <= 4'd8)
        else $error("digit counter above 8");

endmodule

//--- src/record_checker.sv
module record_checker #(
    parameter trace_pkg::word_t    PC_LOW    = 32'h0000_3000,
    parameter trace_pkg::word_t    PC_HIGH   = 32'h0000_4fff,
    parameter trace_pkg::word_t    ADDR_HIGH = 32'h0000_2fff,
    parameter trace_pkg::reg_num_t REG_MAX   = 16'd31
) (
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::trace_record_t record,
    input  logic                     record_valid,
    input  trace_pkg::time_t         freq,
    output trace_pkg::check_result_t result,
    output logic                     result_valid
);
    import trace_pkg::*;

    time_t       half_mask;
    logic        pc_bad;
    logic        addr_bad;
    error_code_t error;

    // freq is a power of two, so this masks below freq/2
    assign half_mask = (freq >> 1) - 16'd1;

    assign pc_bad   = (record.pc < PC_LOW) || (record.pc > PC_HIGH) || (|record.pc[1:0]);
    assign addr_bad = (record.addr > ADDR_HIGH) || (|record.addr[1:0]);

    assign error[0] = |(record.time_val & half_mask);
    assign error[1] = pc_bad;
    assign error[2] = (record.kind == KIND_MEM) && addr_bad;
    assign error[3] = (record.kind == KIND_REG) && (record.reg_num > REG_MAX);

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= record_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (record_valid) begin
            result.kind  <= record.kind;
            result.error <= error;
        end
    end

    // Parser only emits records once the format is known
    a_kind_known: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> result.kind inside {KIND_REG, KIND_MEM})
        else $error("result with no record kind");

endmodule

//--- src/checker_regs.sv
module checker_regs #(
    parameter trace_pkg::time_t FREQ_RESET = 16'd16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::check_result_t result,
    input  logic                     result_valid,
    input  logic [3:0]               awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [3:0]               araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output trace_pkg::time_t         freq
);
    import trace_pkg::*;

    logic          aw_held;
    logic          w_held;
    logic [3:0]    aw_addr_q;
    word_t         w_data_q;
    logic [1:0]    w_strb_q;
    logic          wr_go;
    logic [3:0]    wr_addr;
    word_t         wr_data;
    logic [1:0]    wr_strb;
    word_t         record_count;
    word_t         error_count;
    check_result_t last_result;

    ////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    // AW and W may arrive in either order
    assign wr_go   = (aw_held || (awvalid && awready)) && (w_held || (wvalid && wready));
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb[1:0];

    assign arready = !rvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_held      <= 1'b0;
            w_held       <= 1'b0;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            freq         <= FREQ_RESET;
            record_count <= '0;
            error_count  <= '0;
            last_result  <= '0;
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (awvalid && awready)
                    aw_held <= 1'b1;
                if (wvalid && wready)
                    w_held <= 1'b1;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_go && wr_addr == 4'h0) begin
                if (wr_strb[0])
                    freq[7:0] <= wr_data[7:0];
                if (wr_strb[1])
                    freq[15:8] <= wr_data[15:8];
            end
            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
            if (result_valid) begin
                record_count <= record_count + 32'd1;
                if (|result.error)
                    error_count <= error_count + 32'd1;
                last_result <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready)
            aw_addr_q <= awaddr;
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb[1:0];
        end
        if (arvalid && arready) begin
            case (araddr)
                4'h0:    rdata <= {16'd0, freq};
                4'h4:    rdata <= record_count;
                4'h8:    rdata <= error_count;
                4'hc:    rdata <= {26'd0, last_result};
                default: rdata <= '0;
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

//--- src/trace_checker_top.sv
module trace_checker_top #(
    parameter trace_pkg::word_t    PC_LOW     = 32'h0000_3000,
    parameter trace_pkg::word_t    PC_HIGH    = 32'h0000_4fff,
    parameter trace_pkg::word_t    ADDR_HIGH  = 32'h0000_2fff,
    parameter trace_pkg::reg_num_t REG_MAX    = 16'd31,
    parameter trace_pkg::time_t    FREQ_RESET = 16'd16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  trace_pkg::char_t        char,
    input  logic                    char_valid,
    input  logic [3:0]              awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [3:0]              araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output trace_pkg::record_kind_e result_kind,
    output trace_pkg::error_code_t  result_error,
    output logic                    result_valid
);
    import trace_pkg::*;

    char_token_t   token;
    logic          token_valid;
    trace_record_t record;
    logic          record_valid;
    time_t         freq;
    check_result_t result;

    assign result_kind  = result.kind;
    assign result_error = result.error;

    char_classifier i_char_classifier (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .char_valid  (char_valid),
        .token       (token),
        .token_valid (token_valid)
    );

    trace_parser i_trace_parser (
        .clk          (clk),
        .reset        (reset),
        .token        (token),
        .token_valid  (token_valid),
        .record       (record),
        .record_valid (record_valid)
    );

    record_checker #(
        .PC_LOW    (PC_LOW),
        .PC_HIGH   (PC_HIGH),
        .ADDR_HIGH (ADDR_HIGH),
        .REG_MAX   (REG_MAX)
    ) i_record_checker (
        .clk          (clk),
        .reset        (reset),
        .record       (record),
        .record_valid (record_valid),
        .freq         (freq),
        .result       (result),
        .result_valid (result_valid)
    );

    checker_regs #(
        .FREQ_RESET (FREQ_RESET)
    ) i_checker_regs (
        .clk          (clk),
        .reset        (reset),
        .result       (result),
        .result_valid (result_valid),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .freq         (freq)
    );

endmodule

//--- testbench/tb_trace_checker.sv
module tb_trace_checker;
    import trace_pkg::*;

    localparam word_t    PC_LOW     = 32'h0000_3000;
    localparam word_t    PC_HIGH    = 32'h0000_4fff;
    localparam word_t    ADDR_HIGH  = 32'h0000_2fff;
    localparam reg_num_t REG_MAX    = 16'd31;
    localparam time_t    FREQ_RESET = 16'd16;

    // Fixed lines plus the random back-to-back burst
    localparam int N_FIXED    = 17;
    localparam int N_RANDOM   = 24;
    localparam int N_LINES    = N_FIXED + N_RANDOM;
    localparam int MAX_CYCLES = 40 * N_LINES + 500;

    logic         clk;
    logic         reset;
    char_t        char;
    logic         char_valid;
    logic [3:0]   awaddr;
    logic         awvalid;
    logic         awready;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;
    logic         wvalid;
    logic         wready;
    logic [1:0]   bresp;
    logic         bvalid;
    logic         bready;
    logic [3:0]   araddr;
    logic         arvalid;
    logic         arready;
    logic [31:0]  rdata;
    logic [1:0]   rresp;
    logic         rvalid;
    logic         rready;
    record_kind_e result_kind;
    error_code_t  result_error;
    logic         result_valid;

    check_result_t exp_q[$];
    check_result_t exp_head;
    check_result_t last_exp;
    int            exp_count;
    int            rd_idx;
    int            rec_total;
    int            err_total;
    int            errors;
    int            cycles;
    logic          line_end_good;
    word_t         rd_expect;
    time_t         freq_model;

    trace_checker_top #(
        .PC_LOW     (PC_LOW),
        .PC_HIGH    (PC_HIGH),
        .ADDR_HIGH  (ADDR_HIGH),
        .REG_MAX    (REG_MAX),
        .FREQ_RESET (FREQ_RESET)
    ) i_trace_checker_top (
        .clk          (clk),
        .reset        (reset),
        .char         (char),
        .char_valid   (char_valid),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .result_kind  (result_kind),
        .result_error (result_error),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // Advance to the next expected result while result_valid is stable
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (rd_idx < exp_count)
                exp_head = exp_q[rd_idx];
            else
                exp_head = '0;
            rd_idx++;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_result_value: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (rd_idx <= exp_count && {result_kind, result_error} == exp_head))
        else begin
            errors++;
            $display("ERR %0t: result kind %0d error %b, expected kind %0d error %b",
                     $time, result_kind, result_error, exp_head.kind, exp_head.error);
        end

    a_result_latency: assert property (@(posedge clk) disable iff (reset)
        line_end_good |-> ##3 result_valid)
        else begin
            errors++;
            $display("No result 3 cycles after a well-formed line ended, time %0t", $time);
        end

    a_no_stray_result: assert property (@(posedge clk) disable iff (reset)
        $rose(result_valid) |-> $past(line_end_good, 3))
        else begin
            errors++;
            $display("Result appeared without a well-formed line 3 cycles before, time %0t",
                     $time);
        end

    a_read_data: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> rdata == rd_expect)
        else begin
            errors++;
            $display("ERR %0t: read data %h, expected %h", $time, rdata, rd_expect);
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else begin
            errors++;
            $display("Read response withdrawn before rready, time %0t", $time);
        end

    a_bresp_okay: assert property (@(posedge clk) disable iff (reset)
        bvalid |-> bresp == 2'b00)
        else begin
            errors++;
            $display("ERR %0t: write response %b is not OKAY", $time, bresp);
        end

    a_rresp_okay: assert property (@(posedge clk) disable iff (reset)
        rvalid |-> rresp == 2'b00)
        else begin
            errors++;
            $display("ERR %0t: read response %b is not OKAY", $time, rresp);
        end

    ////////////////////////////////////////
    // Reference model and line generator
    ////////////////////////////////////////

    function automatic check_result_t expected_result(record_kind_e kind, time_t t, word_t pc,
                                                      word_t addr, reg_num_t rn, time_t f);
        check_result_t r;
        r.kind     = kind;
        r.error    = '0;
        r.error[0] = (t % (f / 16'd2)) != 16'd0;
        r.error[1] = (pc < PC_LOW) || (pc > PC_HIGH) || (pc % 32'd4 != 32'd0);
        r.error[2] = (kind == KIND_MEM) && ((addr > ADDR_HIGH) || (addr % 32'd4 != 32'd0));
        r.error[3] = (kind == KIND_REG) && (rn > REG_MAX);
        return r;
    endfunction

    function automatic string spaces(input int n);
        string s;
        s = "";
        for (int i = 0; i < n; i++)
            s = {s, " "};
        return s;
    endfunction

    task automatic drive_text(input string s, input bit good, input check_result_t exp);
        int last;
        last = s.len() - 1;
        for (int i = 0; i <= last; i++) begin
            @(negedge clk);
            char          = s[i];
            char_valid    = 1'b1;
            line_end_good = good && (i == last);
            if (good && i == last) begin
                exp_q.push_back(exp);
                exp_count++;
                rec_total++;
                if (exp.error != 4'd0)
                    err_total++;
                last_exp = exp;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            char_valid    = 1'b0;
            line_end_good = 1'b0;
        end
    endtask

    task automatic drain();
        while (rd_idx != exp_count)
            idle_cycles(1);
        idle_cycles(4);
    endtask

    task automatic send_record(input record_kind_e kind, input time_t t, input word_t pc,
                               input word_t addr, input reg_num_t rn);
        string         s;
        string         sp_colon;
        string         sp_arrow;
        string         sp_data;
        word_t         data;
        check_result_t exp;
        sp_colon = spaces($urandom_range(1, 2));
        sp_arrow = spaces($urandom_range(0, 2));
        sp_data  = spaces($urandom_range(0, 2));
        data     = $urandom();
        if (kind == KIND_REG)
            s = $sformatf("^%0d@%08h:%s$%0d%s<=%s%08h#", t, pc, sp_colon, rn,
                          sp_arrow, sp_data, data);
        else
            s = $sformatf("^%0d@%08h:%s*%08h%s<=%s%08h#", t, pc, sp_colon, addr,
                          sp_arrow, sp_data, data);
        exp = expected_result(kind, t, pc, addr, rn, freq_model);
        drive_text(s, 1'b1, exp);
    endtask

    task automatic send_random_record();
        record_kind_e kind;
        time_t        t;
        word_t        pc;
        word_t        addr;
        reg_num_t     rn;
        kind = ($urandom_range(0, 1) == 0) ? KIND_REG : KIND_MEM;
        t    = time_t'($urandom_range(0, 1249) * 32'd8);
        if ($urandom_range(0, 3) == 0)
            t = t + time_t'($urandom_range(1, 7));
        if ($urandom_range(0, 3) != 0)
            pc = 32'h3000 + 32'd4 * $urandom_range(0, 2047);
        else
            pc = $urandom();
        if ($urandom_range(0, 3) != 0)
            addr = 32'd4 * $urandom_range(0, 3071);
        else
            addr = $urandom();
        rn = reg_num_t'($urandom_range(0, 40));
        send_record(kind, t, pc, addr, rn);
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////

    task automatic axi_write(input logic [3:0] addr, input word_t data);
        bit aw_done;
        bit w_done;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        bready  = 1'b0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            if (awvalid && awready)
                aw_done = 1'b1;
            if (wvalid && wready)
                w_done = 1'b1;
            @(negedge clk);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
        end
        while (!bvalid)
            @(negedge clk);
        // Response waits a cycle before it is taken
        @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read_check(input logic [3:0] addr, input word_t expected);
        @(negedge clk);
        araddr    = addr;
        arvalid   = 1'b1;
        rready    = 1'b0;
        rd_expect = expected;
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        void'($urandom(89405));
        reset         = 1'b1;
        char          = 8'h00;
        char_valid    = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        line_end_good = 1'b0;
        rd_expect     = '0;
        exp_head      = '0;
        last_exp      = '0;
        exp_count     = 0;
        rd_idx        = 0;
        rec_total     = 0;
        err_total     = 0;
        errors        = 0;
        cycles        = 0;
        freq_model    = FREQ_RESET;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        axi_read_check(4'h0, 32'(FREQ_RESET));

        // Clean lines of both formats
        send_record(KIND_REG, 16'd24, 32'h3000, 32'h0, 16'd5);
        idle_cycles(2);
        send_record(KIND_MEM, 16'd1000, 32'h4ffc, 32'h2ffc, 16'd0);
        idle_cycles(2);

        // One violation per line
        send_record(KIND_REG, 16'd13, 32'h3010, 32'h0, 16'd4);
        send_record(KIND_REG, 16'd40, 32'h5000, 32'h0, 16'd4);
        send_record(KIND_REG, 16'd40, 32'h3002, 32'h0, 16'd4);
        send_record(KIND_MEM, 16'd48, 32'h3020, 32'h3000, 16'd0);
        send_record(KIND_MEM, 16'd48, 32'h3020, 32'h1001, 16'd0);
        send_record(KIND_REG, 16'd56, 32'h3024, 32'h0, 16'd32);
        drain();

        // Malformed lines
        drive_text("^12345@00003000: $1 <= 00000000#", 1'b0, '0);
        idle_cycles(2);
        drive_text("^10@0003000: $1 <= 00000000#", 1'b0, '0);
        idle_cycles(2);
        drive_text("^10@00003000 $1 <= 00000000#", 1'b0, '0);
        idle_cycles(2);
        drive_text("^10@00003000: $1 <= 0000g000#", 1'b0, '0);
        idle_cycles(2);
        drive_text("^10@00003000: $1 <= 000000000#", 1'b0, '0);
        idle_cycles(2);
        drive_text("^40@00003000: *0000", 1'b0, '0);
        send_record(KIND_MEM, 16'd40, 32'h3000, 32'h10, 16'd0);
        drain();

        // Back-to-back burst
        for (int n = 0; n < N_RANDOM; n++)
            send_random_record();
        drain();

        // New frequency moves the time-flag boundary
        axi_write(4'h0, 32'd64);
        freq_model = 16'd64;
        axi_read_check(4'h0, 32'd64);
        send_record(KIND_REG, 16'd16, 32'h3100, 32'h0, 16'd7);
        send_record(KIND_REG, 16'd96, 32'h3104, 32'h0, 16'd7);
        drain();

        axi_read_check(4'h4, 32'(rec_total));
        axi_read_check(4'h8, 32'(err_total));
        axi_read_check(4'hc, {26'd0, last_exp});
        axi_write(4'h4, 32'hdead_beef);
        axi_read_check(4'h4, 32'(rec_total));
        idle_cycles(4);

        a_all_results: assert (rd_idx == exp_count)
            else begin
                errors++;
                $display("Result count wrong: %0d results seen, %0d lines expected one",
                         rd_idx, exp_count);
            end
        $display("Results checked: %0d, errors: %0d", rd_idx, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- sim.f
src/trace_pkg.sv
src/char_classifier.sv
src/trace_parser.sv
src/record_checker.sv
src/checker_regs.sv
src/trace_checker_top.sv
testbench/tb_trace_checker.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_trace_checker -o tb_sim \
    || exit 1
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
